//--- flist.f
+incdir+include
source/btb_pkg.sv
source/btb_mem_if.sv
source/btb_set_ram.sv
source/btb_arbiter.sv
source/btb_lookup.sv
source/btb_update.sv
source/btb_top.sv
verification/btb_assertions.sv
verification/btb_tb.sv

//--- include/btb_cfg.svh
// Branch target buffer sizes
`ifndef BTB_CFG_SVH
`define BTB_CFG_SVH

// Address split: tag | index | word offset
`define BTB_ADDR_BITS     32
`define BTB_INDEX_BITS    10
`define BTB_INDEX_LSB     2
`define BTB_TAG_BITS      20
`define BTB_TAG_ADDR_LSB  12

// Geometry
`define BTB_SETS          1024
`define BTB_WAYS          2

// Set word: {lru, way1, way0}, each way is {tag, target}
`define BTB_WAY_BITS      52
`define BTB_SET_BITS      105
`define BTB_TGT_POS       0
`define BTB_TAG_POS       32
`define BTB_WAY1_POS      52
`define BTB_LRU_POS       104

`endif

//--- source/btb_arbiter.sv
// Set memory arbiter
`timescale 1ns/1ps

module btb_arbiter (
    input  logic                CLK,
    input  logic                RESET,
    btb_mem_if.arbiter          lk,
    btb_mem_if.arbiter          up,
    output btb_pkg::btb_index_t index,
    output logic                we,
    output btb_pkg::btb_set_t   wdata,
    output btb_pkg::btb_valid_t wvalid,
    input  btb_pkg::btb_set_t   rdata,
    input  btb_pkg::btb_valid_t rvalid
);

    logic lk_own;
    logic up_own;
    logic free;
    logic gnt_lk;
    logic gnt_up;

    // Nobody holds the memory
    assign free = !lk_own && !up_own;

    // Update has priority when both ask on a free cycle
    assign gnt_up = up_own || (free && up.req);
    assign gnt_lk = lk_own || (free && !up.req && lk.req);

    // Ownership lasts while req stays high; the write cycle drops req and
    // still sees the grant from the owner flop
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            lk_own <= 1'b0;
            up_own <= 1'b0;
        end else begin
            lk_own <= gnt_lk && lk.req;
            up_own <= gnt_up && up.req;
        end
    end

    assign lk.gnt = gnt_lk;
    assign up.gnt = gnt_up;

    // Owner's request onto the memory
    assign index  = gnt_up ? up.index  : lk.index;
    assign wdata  = gnt_up ? up.wdata  : lk.wdata;
    assign wvalid = gnt_up ? up.wvalid : lk.wvalid;
    assign we     = (gnt_up && up.we) || (gnt_lk && lk.we);

    // Read data goes to both, only the owner looks at it
    assign lk.rdata  = rdata;
    assign lk.rvalid = rvalid;
    assign up.rdata  = rdata;
    assign up.rvalid = rvalid;

endmodule

//--- source/btb_lookup.sv
// Branch target buffer lookup engine
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_lookup (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               lookup_req,
    input  btb_pkg::btb_addr_t lookup_pc,
    output logic               lookup_busy,
    output logic               pred_done,
    output logic               pred_hit,
    output btb_pkg::btb_addr_t pred_target,
    btb_mem_if.client          mem
);

    btb_pkg::lookup_state_t state_q;
    btb_pkg::btb_addr_t     pc_q;
    btb_pkg::btb_set_t      set_q;
    btb_pkg::btb_valid_t    vld_q;
    btb_pkg::btb_set_t      new_set;
    btb_pkg::btb_tag_t      tag;
    logic                   hit0;
    logic                   hit1;
    logic                   hit;
    btb_pkg::btb_addr_t     hit_target;

    assign tag = pc_q[`BTB_TAG_ADDR_LSB +: `BTB_TAG_BITS];

    // Tag compare on both ways, way 0 first
    assign hit0 = mem.rvalid[0] && (mem.rdata[`BTB_TAG_POS +: `BTB_TAG_BITS] == tag);
    assign hit1 = mem.rvalid[1] &&
                  (mem.rdata[`BTB_WAY1_POS + `BTB_TAG_POS +: `BTB_TAG_BITS] == tag);
    assign hit  = hit0 || hit1;
    assign hit_target = hit0 ? mem.rdata[`BTB_TGT_POS +: `BTB_ADDR_BITS]
                             : mem.rdata[`BTB_WAY1_POS + `BTB_TGT_POS +: `BTB_ADDR_BITS];

    // Touch LRU on a hit, a miss writes the set back as read
    always_comb begin
        new_set = mem.rdata;
        if (hit) begin
            new_set[`BTB_LRU_POS] = !hit0;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state_q     <= btb_pkg::LK_IDLE;
            pred_done   <= 1'b0;
            pred_hit    <= 1'b0;
            pred_target <= '0;
        end else begin
            pred_done <= 1'b0;
            case (state_q)
                btb_pkg::LK_IDLE: begin
                    if (lookup_req) state_q <= btb_pkg::LK_REQ;
                end
                btb_pkg::LK_REQ: begin
                    if (mem.gnt) state_q <= btb_pkg::LK_READ;
                end
                btb_pkg::LK_READ: begin
                    state_q     <= btb_pkg::LK_WRITE;
                    pred_done   <= 1'b1;
                    pred_hit    <= hit;
                    pred_target <= hit ? hit_target : '0;
                end
                default: state_q <= btb_pkg::LK_IDLE;
            endcase
        end
    end

    // PC and write-back set
    always_ff @(posedge CLK) begin
        if (state_q == btb_pkg::LK_IDLE && lookup_req) pc_q <= lookup_pc;
        if (state_q == btb_pkg::LK_READ) begin
            set_q <= new_set;
            vld_q <= mem.rvalid;
        end
    end

    assign lookup_busy = (state_q != btb_pkg::LK_IDLE);

    assign mem.req    = (state_q == btb_pkg::LK_REQ) || (state_q == btb_pkg::LK_READ);
    assign mem.we     = (state_q == btb_pkg::LK_WRITE);
    assign mem.index  = pc_q[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];
    assign mem.wdata  = set_q;
    assign mem.wvalid = vld_q;

endmodule

//--- source/btb_mem_if.sv
// Set memory client port
`timescale 1ns/1ps

interface btb_mem_if;

    // Request side, driven by the engine
    logic                  req;
    logic                  we;
    btb_pkg::btb_index_t   index;
    btb_pkg::btb_set_t     wdata;
    btb_pkg::btb_valid_t   wvalid;

    // Response side, driven by the arbiter
    logic                  gnt;
    btb_pkg::btb_set_t     rdata;
    btb_pkg::btb_valid_t   rvalid;

    // Engine view
    modport client (
        output req,
        output we,
        output index,
        output wdata,
        output wvalid,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    // Arbiter view
    modport arbiter (
        input  req,
        input  we,
        input  index,
        input  wdata,
        input  wvalid,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

//--- source/btb_pkg.sv
// Branch target buffer types
`include "btb_cfg.svh"

package btb_pkg;

    // Branch PC or predicted target
    typedef logic [`BTB_ADDR_BITS-1:0]  btb_addr_t;

    // Set select, taken from PC bits 11:2
    typedef logic [`BTB_INDEX_BITS-1:0] btb_index_t;

    // Upper PC bits kept per way
    typedef logic [`BTB_TAG_BITS-1:0]   btb_tag_t;

    // One stored set, two ways plus the LRU bit
    typedef logic [`BTB_SET_BITS-1:0]   btb_set_t;

    // Valid bit per way, bit 0 for way 0
    typedef logic [`BTB_WAYS-1:0]       btb_valid_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_REQ,
        LK_READ,
        LK_WRITE
    } lookup_state_t;

    typedef enum logic [1:0] {
        UP_IDLE,
        UP_REQ,
        UP_READ,
        UP_WRITE
    } update_state_t;

endpackage

//--- source/btb_set_ram.sv
// Branch target buffer set memory
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_set_ram (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                flush,
    input  btb_pkg::btb_index_t index,
    input  logic                we,
    input  btb_pkg::btb_set_t   wdata,
    input  btb_pkg::btb_valid_t wvalid,
    output btb_pkg::btb_set_t   rdata,
    output btb_pkg::btb_valid_t rvalid
);

    btb_pkg::btb_set_t   sets    [`BTB_SETS];
    btb_pkg::btb_valid_t valid_q [`BTB_SETS];

    // Tags, targets and LRU, single port
    always_ff @(posedge CLK) begin
        if (we) begin
            sets[index] <= wdata;
        end else begin
            rdata <= sets[index];
        end
    end

    // Valid bits sit in flops so a flush can wipe them in one edge
    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            for (int i = 0; i < `BTB_SETS; i++) begin
                valid_q[i] <= '0;
            end
            rvalid <= '0;
        end else if (flush) begin
            for (int i = 0; i < `BTB_SETS; i++) begin
                valid_q[i] <= '0;
            end
        end else if (we) begin
            valid_q[index] <= wvalid;
        end else begin
            rvalid <= valid_q[index];
        end
    end

endmodule

//--- source/btb_top.sv
// Branch target buffer top level
`timescale 1ns/1ps

module btb_top (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               flush,
    input  logic               lookup_req,
    input  btb_pkg::btb_addr_t lookup_pc,
    input  logic               resolve_valid,
    input  btb_pkg::btb_addr_t resolve_pc,
    input  btb_pkg::btb_addr_t resolve_target,
    output logic               lookup_busy,
    output logic               update_busy,
    output logic               pred_done,
    output logic               pred_hit,
    output btb_pkg::btb_addr_t pred_target
);

    btb_pkg::btb_index_t ram_index;
    logic                ram_we;
    btb_pkg::btb_set_t   ram_wdata;
    btb_pkg::btb_valid_t ram_wvalid;
    btb_pkg::btb_set_t   ram_rdata;
    btb_pkg::btb_valid_t ram_rvalid;

    // One port per engine
    btb_mem_if mem_lk ();
    btb_mem_if mem_up ();

    btb_lookup u_lookup (
        .CLK         (CLK),
        .RESET       (RESET),
        .lookup_req  (lookup_req),
        .lookup_pc   (lookup_pc),
        .lookup_busy (lookup_busy),
        .pred_done   (pred_done),
        .pred_hit    (pred_hit),
        .pred_target (pred_target),
        .mem         (mem_lk.client)
    );

    btb_update u_update (
        .CLK            (CLK),
        .RESET          (RESET),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .update_busy    (update_busy),
        .mem            (mem_up.client)
    );

    btb_arbiter u_arbiter (
        .CLK    (CLK),
        .RESET  (RESET),
        .lk     (mem_lk.arbiter),
        .up     (mem_up.arbiter),
        .index  (ram_index),
        .we     (ram_we),
        .wdata  (ram_wdata),
        .wvalid (ram_wvalid),
        .rdata  (ram_rdata),
        .rvalid (ram_rvalid)
    );

    btb_set_ram u_set_ram (
        .CLK    (CLK),
        .RESET  (RESET),
        .flush  (flush),
        .index  (ram_index),
        .we     (ram_we),
        .wdata  (ram_wdata),
        .wvalid (ram_wvalid),
        .rdata  (ram_rdata),
        .rvalid (ram_rvalid)
    );

endmodule

//--- source/btb_update.sv
// Branch target buffer update engine
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_update (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               resolve_valid,
    input  btb_pkg::btb_addr_t resolve_pc,
    input  btb_pkg::btb_addr_t resolve_target,
    output logic               update_busy,
    btb_mem_if.client          mem
);

    btb_pkg::update_state_t state_q;
    btb_pkg::btb_addr_t     pc_q;
    btb_pkg::btb_addr_t     tgt_q;
    btb_pkg::btb_set_t      set_q;
    btb_pkg::btb_valid_t    vld_q;
    btb_pkg::btb_set_t      new_set;
    btb_pkg::btb_valid_t    new_vld;
    btb_pkg::btb_tag_t      tag;
    logic                   accept;
    logic                   match0;
    logic                   match1;
    logic                   use_way1;

    // A zero target carries no prediction
    assign accept = resolve_valid && (resolve_target != '0);

    assign tag = pc_q[`BTB_TAG_ADDR_LSB +: `BTB_TAG_BITS];

    assign match0 = mem.rvalid[0] && (mem.rdata[`BTB_TAG_POS +: `BTB_TAG_BITS] == tag);
    assign match1 = mem.rvalid[1] &&
                    (mem.rdata[`BTB_WAY1_POS + `BTB_TAG_POS +: `BTB_TAG_BITS] == tag);

    // Reuse the matching way, else take the LRU one (LRU 1 means way 0)
    assign use_way1 = !match0 && (match1 || !mem.rdata[`BTB_LRU_POS]);

    always_comb begin
        logic [`BTB_WAY_BITS-1:0] entry;
        entry = '0;
        entry[`BTB_TAG_POS +: `BTB_TAG_BITS]  = tag;
        entry[`BTB_TGT_POS +: `BTB_ADDR_BITS] = tgt_q;
        new_set = mem.rdata;
        new_vld = mem.rvalid;
        if (use_way1) begin
            new_set[`BTB_WAY1_POS +: `BTB_WAY_BITS] = entry;
            new_vld[1] = 1'b1;
        end else begin
            new_set[0 +: `BTB_WAY_BITS] = entry;
            new_vld[0] = 1'b1;
        end
        // Other way becomes least recently used
        new_set[`BTB_LRU_POS] = use_way1;
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            state_q <= btb_pkg::UP_IDLE;
        end else begin
            case (state_q)
                btb_pkg::UP_IDLE: begin
                    if (accept) state_q <= btb_pkg::UP_REQ;
                end
                btb_pkg::UP_REQ: begin
                    if (mem.gnt) state_q <= btb_pkg::UP_READ;
                end
                btb_pkg::UP_READ: state_q <= btb_pkg::UP_WRITE;
                default:          state_q <= btb_pkg::UP_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state_q == btb_pkg::UP_IDLE && accept) begin
            pc_q  <= resolve_pc;
            tgt_q <= resolve_target;
        end
        if (state_q == btb_pkg::UP_READ) begin
            set_q <= new_set;
            vld_q <= new_vld;
        end
    end

    assign update_busy = (state_q != btb_pkg::UP_IDLE);

    assign mem.req    = (state_q == btb_pkg::UP_REQ) || (state_q == btb_pkg::UP_READ);
    assign mem.we     = (state_q == btb_pkg::UP_WRITE);
    assign mem.index  = pc_q[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];
    assign mem.wdata  = set_q;
    assign mem.wvalid = vld_q;

endmodule

//--- verification/btb_assertions.sv
// Branch target buffer protocol checks
`timescale 1ns/1ps

module btb_assertions (
    input logic CLK,
    input logic RESET,
    input logic flush,
    input logic lookup_req,
    input logic lookup_busy,
    input logic resolve_valid,
    input logic update_busy,
    input logic gnt_lk,
    input logic gnt_up,
    input logic we_lk,
    input logic we_up
);

    int assert_errors = 0;

    // One owner of the set memory at a time
    grant_exclusive: assert property (@(posedge CLK) disable iff (!RESET)
        !(gnt_lk && gnt_up))
    else begin
        $error("Lookup and update grants are high together");
        assert_errors++;
    end

    // Each engine writes only while it holds the grant
    lookup_write_granted: assert property (@(posedge CLK) disable iff (!RESET)
        we_lk |-> gnt_lk)
    else begin
        $error("Lookup engine writes the set memory without its grant");
        assert_errors++;
    end

    update_write_granted: assert property (@(posedge CLK) disable iff (!RESET)
        we_up |-> gnt_up)
    else begin
        $error("Update engine writes the set memory without its grant");
        assert_errors++;
    end

    lookup_strobe_idle: assert property (@(posedge CLK) disable iff (!RESET)
        lookup_req |-> !lookup_busy)
    else begin
        $error("Lookup strobe while the lookup engine is busy");
        assert_errors++;
    end

    resolve_strobe_idle: assert property (@(posedge CLK) disable iff (!RESET)
        resolve_valid |-> !update_busy)
    else begin
        $error("Resolve strobe while the update engine is busy");
        assert_errors++;
    end

    // Flush only with both engines idle
    flush_idle: assert property (@(posedge CLK) disable iff (!RESET)
        flush |-> (!lookup_busy && !update_busy))
    else begin
        $error("Flush while an engine is busy");
        assert_errors++;
    end

endmodule

bind btb_top btb_assertions u_assertions (
    .CLK           (CLK),
    .RESET         (RESET),
    .flush         (flush),
    .lookup_req    (lookup_req),
    .lookup_busy   (lookup_busy),
    .resolve_valid (resolve_valid),
    .update_busy   (update_busy),
    .gnt_lk        (mem_lk.gnt),
    .gnt_up        (mem_up.gnt),
    .we_lk         (mem_lk.we),
    .we_up         (mem_up.we)
);

//--- verification/btb_tb.sv
// Branch target buffer testbench
`timescale 1ns/1ps
`include "btb_cfg.svh"

module btb_tb;

    localparam int WAIT_LIMIT = 50;

    logic               CLK;
    logic               RESET;
    logic               flush;
    logic               lookup_req;
    btb_pkg::btb_addr_t lookup_pc;
    logic               resolve_valid;
    btb_pkg::btb_addr_t resolve_pc;
    btb_pkg::btb_addr_t resolve_target;
    logic               lookup_busy;
    logic               update_busy;
    logic               pred_done;
    logic               pred_hit;
    btb_pkg::btb_addr_t pred_target;

    int errors;
    int checks;

    // Reference model with slot 0 as the most recently used entry of a set
    logic               ref_vld [`BTB_SETS][2];
    btb_pkg::btb_tag_t  ref_tag [`BTB_SETS][2];
    btb_pkg::btb_addr_t ref_tgt [`BTB_SETS][2];

    btb_top uut (
        .CLK            (CLK),
        .RESET          (RESET),
        .flush          (flush),
        .lookup_req     (lookup_req),
        .lookup_pc      (lookup_pc),
        .resolve_valid  (resolve_valid),
        .resolve_pc     (resolve_pc),
        .resolve_target (resolve_target),
        .lookup_busy    (lookup_busy),
        .update_busy    (update_busy),
        .pred_done      (pred_done),
        .pred_hit       (pred_hit),
        .pred_target    (pred_target)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // PC bits 11:2 select the set and bits 31:12 are the tag
    function automatic btb_pkg::btb_index_t index_of(input btb_pkg::btb_addr_t pc);
        return pc[`BTB_INDEX_LSB +: `BTB_INDEX_BITS];
    endfunction

    function automatic btb_pkg::btb_tag_t tag_of(input btb_pkg::btb_addr_t pc);
        return pc[`BTB_TAG_ADDR_LSB +: `BTB_TAG_BITS];
    endfunction

    function automatic btb_pkg::btb_addr_t make_pc(input btb_pkg::btb_tag_t tag,
                                                   input btb_pkg::btb_index_t idx);
        return {tag, idx, 2'b00};
    endfunction

    // Never zero
    function automatic btb_pkg::btb_addr_t rand_target();
        return $urandom() | 32'h4;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < `BTB_SETS; i++) begin
            ref_vld[i][0] = 1'b0;
            ref_vld[i][1] = 1'b0;
        end
    endtask

    // Same tag reuses its slot and a new tag pushes the older slot out
    task automatic model_resolve(input btb_pkg::btb_addr_t pc, input btb_pkg::btb_addr_t tgt);
        btb_pkg::btb_index_t idx;
        btb_pkg::btb_tag_t   tag;
        idx = index_of(pc);
        tag = tag_of(pc);
        if (tgt != '0) begin
            if (!(ref_vld[idx][0] && ref_tag[idx][0] == tag)) begin
                ref_vld[idx][1] = ref_vld[idx][0];
                ref_tag[idx][1] = ref_tag[idx][0];
                ref_tgt[idx][1] = ref_tgt[idx][0];
            end
            ref_vld[idx][0] = 1'b1;
            ref_tag[idx][0] = tag;
            ref_tgt[idx][0] = tgt;
        end
    endtask

    task automatic model_lookup(input btb_pkg::btb_addr_t pc, output logic hit,
                                output btb_pkg::btb_addr_t tgt);
        btb_pkg::btb_index_t idx;
        btb_pkg::btb_tag_t   tag;
        idx = index_of(pc);
        tag = tag_of(pc);
        hit = 1'b0;
        tgt = '0;
        if (ref_vld[idx][0] && ref_tag[idx][0] == tag) begin
            hit = 1'b1;
            tgt = ref_tgt[idx][0];
        end else if (ref_vld[idx][1] && ref_tag[idx][1] == tag) begin
            // Hit on the older slot makes it the most recent
            hit = 1'b1;
            tgt = ref_tgt[idx][1];
            ref_tag[idx][1] = ref_tag[idx][0];
            ref_tgt[idx][1] = ref_tgt[idx][0];
            ref_tag[idx][0] = tag;
            ref_tgt[idx][0] = tgt;
        end
    endtask

    task automatic check_hit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_target(input btb_pkg::btb_addr_t got, input btb_pkg::btb_addr_t exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            $display("** Error at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        int sva_errors;
        sva_errors = uut.u_assertions.assert_errors;
        $display("Checks: %0d, errors: %0d, assertion errors: %0d", checks, errors, sva_errors);
        if (errors == 0 && sva_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    // Cycles count from the edge that drove the strobe
    task automatic wait_done(input bit for_update, output int cycles);
        bit done;
        cycles = 1;
        done = 1'b0;
        while (!done) begin
            @(negedge CLK);
            if (for_update ? !update_busy : pred_done) begin
                done = 1'b1;
            end else if (cycles == WAIT_LIMIT) begin
                $display("Timeout: the %s engine did not finish within %0d cycles",
                         for_update ? "update" : "lookup", WAIT_LIMIT);
                errors++;
                finish_run();
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic compare_prediction(input btb_pkg::btb_addr_t pc);
        logic               exp_hit;
        btb_pkg::btb_addr_t exp_tgt;
        model_lookup(pc, exp_hit, exp_tgt);
        check_hit(pred_hit, exp_hit, $sformatf("pred_hit for pc %h", pc));
        check_target(pred_target, exp_tgt, $sformatf("pred_target for pc %h", pc));
    endtask

    task automatic do_reset();
        RESET <= 1'b0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b1;
        @(negedge CLK);
        check_hit(pred_done, 1'b0, "pred_done after reset");
        check_hit(pred_hit, 1'b0, "pred_hit after reset");
        check_hit(lookup_busy, 1'b0, "lookup_busy after reset");
        check_hit(update_busy, 1'b0, "update_busy after reset");
        check_target(pred_target, '0, "pred_target after reset");
        model_clear();
    endtask

    task automatic do_lookup(input btb_pkg::btb_addr_t pc);
        int cycles;
        @(posedge CLK);
        lookup_req <= 1'b1;
        lookup_pc  <= pc;
        @(posedge CLK);
        lookup_req <= 1'b0;
        wait_done(1'b0, cycles);
        check_cycles(cycles, 3, "uncontended lookup latency");
        // Write-back still pending when the result comes out
        check_hit(lookup_busy, 1'b1, "lookup_busy with pred_done");
        compare_prediction(pc);
    endtask

    task automatic do_resolve(input btb_pkg::btb_addr_t pc, input btb_pkg::btb_addr_t tgt);
        int cycles;
        @(posedge CLK);
        resolve_valid  <= 1'b1;
        resolve_pc     <= pc;
        resolve_target <= tgt;
        @(posedge CLK);
        resolve_valid <= 1'b0;
        wait_done(1'b1, cycles);
        model_resolve(pc, tgt);
    endtask

    task automatic do_flush();
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        model_clear();
    endtask

    // Update wins the memory, so the lookup sees the resolved entry
    task automatic do_both(input btb_pkg::btb_addr_t lpc, input btb_pkg::btb_addr_t rpc,
                           input btb_pkg::btb_addr_t rtgt);
        int cycles;
        @(posedge CLK);
        lookup_req     <= 1'b1;
        lookup_pc      <= lpc;
        resolve_valid  <= 1'b1;
        resolve_pc     <= rpc;
        resolve_target <= rtgt;
        @(posedge CLK);
        lookup_req    <= 1'b0;
        resolve_valid <= 1'b0;
        wait_done(1'b0, cycles);
        model_resolve(rpc, rtgt);
        compare_prediction(lpc);
        wait_done(1'b1, cycles);
    endtask

    task automatic test_cold_miss();
        repeat (8) do_lookup($urandom());
    endtask

    // Sets leave reset without a defined LRU bit; one fill and one hit per set fixes it
    task automatic prime_sets();
        for (int i = 0; i < `BTB_SETS; i++) begin
            do_resolve(make_pc(20'hfffff, i), rand_target());
            do_lookup(make_pc(20'hfffff, i));
        end
        do_flush();
    endtask

    task automatic test_resolve_hit();
        btb_pkg::btb_addr_t pc;
        repeat (4) begin
            pc = $urandom();
            do_resolve(pc, rand_target());
            do_lookup(pc);
            pc = $urandom();
            do_resolve(pc, '0);
            do_lookup(pc);
        end
    endtask

    // The second tag is most recent when it is resolved again, so a wrong way choice evicts
    // the first tag
    task automatic test_same_set();
        btb_pkg::btb_index_t idx;
        btb_pkg::btb_tag_t   tag;
        idx = $urandom();
        tag = $urandom();
        do_resolve(make_pc(tag, idx), rand_target());
        do_resolve(make_pc(tag + 1, idx), rand_target());
        do_lookup(make_pc(tag, idx));
        do_lookup(make_pc(tag + 1, idx));
        do_resolve(make_pc(tag + 1, idx), rand_target());
        do_lookup(make_pc(tag, idx));
        do_lookup(make_pc(tag + 1, idx));
    endtask

    task automatic test_evict();
        btb_pkg::btb_index_t idx;
        btb_pkg::btb_tag_t   tag;
        tag = $urandom();
        for (int pass = 0; pass < 2; pass++) begin
            idx = $urandom();
            do_resolve(make_pc(tag, idx), rand_target());
            do_resolve(make_pc(tag + 1, idx), rand_target());
            // A hit on the first tag moves the victim to the second
            if (pass == 1) do_lookup(make_pc(tag, idx));
            do_resolve(make_pc(tag + 2, idx), rand_target());
            for (int t = 0; t < 3; t++) do_lookup(make_pc(tag + t, idx));
        end
    endtask

    task automatic test_flush();
        btb_pkg::btb_addr_t pcs [4];
        foreach (pcs[i]) begin
            pcs[i] = $urandom();
            do_resolve(pcs[i], rand_target());
        end
        do_flush();
        foreach (pcs[i]) do_lookup(pcs[i]);
        foreach (pcs[i]) begin
            do_resolve(pcs[i], rand_target());
            do_lookup(pcs[i]);
        end
    endtask

    task automatic test_contention();
        btb_pkg::btb_addr_t pc;
        pc = $urandom();
        do_both(pc, pc, rand_target());
        do_both(pc, pc ^ 32'h0000_1000, rand_target());
        do_both(pc ^ 32'h0000_1000, pc, rand_target());
    endtask

    // Small pool of sets and tags to force reuse and eviction
    task automatic test_random();
        btb_pkg::btb_addr_t pc;
        btb_pkg::btb_addr_t tgt;
        int                 op;
        repeat (300) begin
            op  = $urandom_range(0, 9);
            pc  = make_pc($urandom_range(0, 3), $urandom_range(0, 3));
            tgt = ($urandom_range(0, 7) == 0) ? '0 : rand_target();
            if (op < 4) begin
                do_lookup(pc);
            end else if (op < 7) begin
                do_resolve(pc, tgt);
            end else if (op < 9) begin
                do_both(make_pc($urandom_range(0, 3), $urandom_range(0, 3)), pc, tgt);
            end else begin
                do_flush();
            end
        end
    endtask

    initial begin
        void'($urandom(81));
        errors         = 0;
        checks         = 0;
        RESET          = 1'b0;
        flush          = 1'b0;
        lookup_req     = 1'b0;
        lookup_pc      = '0;
        resolve_valid  = 1'b0;
        resolve_pc     = '0;
        resolve_target = '0;
        do_reset();
        test_cold_miss();
        prime_sets();
        test_resolve_hit();
        test_same_set();
        test_evict();
        test_flush();
        test_contention();
        test_random();
        finish_run();
    end

endmodule
